// ==== hdl/llc_defs.svh ====
`ifndef LLC_DEFS_SVH
`define LLC_DEFS_SVH

// Address split is tag | index | offset
`define LLC_ADDR_BITS      64
`define LLC_LINE_COUNT     16
`define LLC_BYTES_PER_LINE 64
`define LLC_OFFSET_BITS    6
`define LLC_INDEX_BITS     4
`define LLC_TAG_BITS       (`LLC_ADDR_BITS - `LLC_INDEX_BITS - `LLC_OFFSET_BITS)

// AXI data beats
`define LLC_BEAT_BITS      64
`define LLC_BEATS_PER_LINE 8
`define LLC_LINE_BITS      (`LLC_BYTES_PER_LINE * 8)

`endif

// ==== hdl/llc_pkg.sv ====
package llc_pkg;

`include "llc_defs.svh"

    typedef logic [`LLC_ADDR_BITS-1:0]  addr_t;
    typedef logic [`LLC_TAG_BITS-1:0]   tag_t;
    typedef logic [`LLC_INDEX_BITS-1:0] index_t;
    typedef logic [`LLC_BEAT_BITS-1:0]  beat_t;
    typedef logic [`LLC_LINE_BITS-1:0]  line_data_t;
    typedef logic [$clog2(`LLC_BEATS_PER_LINE)-1:0] beat_count_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } line_meta_t;

    function automatic tag_t addr_tag(addr_t addr);
        return addr[`LLC_ADDR_BITS-1 -: `LLC_TAG_BITS];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[`LLC_OFFSET_BITS +: `LLC_INDEX_BITS];
    endfunction

    // Rebuild a line-aligned byte address
    function automatic addr_t line_addr(tag_t tag, index_t index);
        return {tag, index, {`LLC_OFFSET_BITS{1'b0}}};
    endfunction

endpackage

// ==== hdl/llc_line_store.sv ====
`timescale 1ns/10ps
`include "llc_defs.svh"

module llc_line_store (
    input  logic                clk,
    input  logic                reset,
    input  llc_pkg::addr_t      rd_addr,
    output llc_pkg::line_data_t rd_data,
    output logic                rd_hit,
    output llc_pkg::line_meta_t rd_victim_meta,
    input  llc_pkg::addr_t      wr_lookup_addr,
    output llc_pkg::line_meta_t wr_victim_meta,
    output llc_pkg::line_data_t wr_victim_line,
    input  logic                install_en,
    input  llc_pkg::index_t     install_index,
    input  llc_pkg::line_meta_t install_meta,
    input  llc_pkg::line_data_t install_line,
    input  logic                inv_en,
    input  llc_pkg::index_t     inv_index
);
    import llc_pkg::*;

    logic [`LLC_LINE_COUNT-1:0] valid_q;
    logic [`LLC_LINE_COUNT-1:0] dirty_q;
    tag_t                       tag_q  [`LLC_LINE_COUNT];
    line_data_t                 data_q [`LLC_LINE_COUNT];
    index_t                     rd_index;
    index_t                     wr_index;

    assign rd_index = addr_index(rd_addr);
    assign wr_index = addr_index(wr_lookup_addr);

    // Zero-latency read port
    assign rd_data = data_q[rd_index];
    assign rd_hit  = valid_q[rd_index] && (tag_q[rd_index] == addr_tag(rd_addr));

    always_comb begin
        rd_victim_meta.valid = valid_q[rd_index];
        rd_victim_meta.dirty = dirty_q[rd_index];
        rd_victim_meta.tag   = tag_q[rd_index];
        // Line the buffered write would displace
        wr_victim_meta.valid = valid_q[wr_index];
        wr_victim_meta.dirty = dirty_q[wr_index];
        wr_victim_meta.tag   = tag_q[wr_index];
    end

    assign wr_victim_line = data_q[wr_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            if (inv_en) valid_q[inv_index] <= 1'b0;  // Line under refill
            if (install_en) valid_q[install_index] <= install_meta.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (install_en) begin
            dirty_q[install_index] <= install_meta.dirty;
            tag_q[install_index]   <= install_meta.tag;
            data_q[install_index]  <= install_line;
        end
    end

endmodule

// ==== hdl/llc_miss_ctrl.sv ====
`timescale 1ns/10ps

module llc_miss_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  llc_pkg::addr_t      rd_addr,
    input  logic                rd_addr_valid,
    input  logic                rd_hit,
    input  llc_pkg::line_meta_t rd_victim_meta,
    input  llc_pkg::line_data_t rd_data,
    input  logic                wr_valid,
    input  llc_pkg::addr_t      wr_addr,
    input  llc_pkg::line_data_t wr_data,
    output logic                wr_ready,
    output logic                wr_complete,
    output llc_pkg::addr_t      wr_lookup_addr,
    input  llc_pkg::line_meta_t wr_victim_meta,
    input  llc_pkg::line_data_t wr_victim_line,
    output logic                install_en,
    output llc_pkg::index_t     install_index,
    output llc_pkg::line_meta_t install_meta,
    output llc_pkg::line_data_t install_line,
    output logic                inv_en,
    output llc_pkg::index_t     inv_index,
    output logic                refill_start,
    output llc_pkg::addr_t      refill_addr,
    input  logic                refill_done,
    input  llc_pkg::line_data_t refill_line,
    output logic                wb_start,
    output llc_pkg::addr_t      wb_addr,
    output llc_pkg::line_data_t wb_line,
    input  logic                wb_done
);
    import llc_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REFILL_WB,
        ST_REFILL,
        ST_WR_EVICT,
        ST_WR_DONE
    } state_t;

    state_t     state;
    state_t     state_next;
    logic       wbuf_valid;
    addr_t      wbuf_addr;
    line_data_t wbuf_data;
    addr_t      miss_addr;
    logic       last_was_read;
    logic       refill_seen;  // Refill finished while writeback still busy
    logic       read_req;
    logic       serve_read;
    logic       serve_write;
    logic       rd_victim_dirty;
    logic       wr_conflict;

    assign read_req        = rd_addr_valid && !rd_hit;
    assign rd_victim_dirty = rd_victim_meta.valid && rd_victim_meta.dirty;
    assign wr_conflict     = wr_victim_meta.valid && wr_victim_meta.dirty &&
                             (wr_victim_meta.tag != addr_tag(wbuf_addr));

    // Take turns when a read miss and a buffered write both wait
    assign serve_write = (state == ST_IDLE) && wbuf_valid && (!read_req || last_was_read);
    assign serve_read  = (state == ST_IDLE) && read_req && !serve_write;

    assign wr_ready       = !wbuf_valid;
    assign wr_complete    = (state == ST_WR_DONE);
    assign wr_lookup_addr = wbuf_addr;

    assign inv_en       = serve_read;
    assign inv_index    = addr_index(rd_addr);
    assign refill_start = serve_read;
    assign refill_addr  = line_addr(addr_tag(rd_addr), addr_index(rd_addr));

    assign wb_start = (serve_read && rd_victim_dirty) || (serve_write && wr_conflict);

    always_comb begin
        if (serve_write) begin
            wb_addr = line_addr(wr_victim_meta.tag, addr_index(wbuf_addr));
            wb_line = wr_victim_line;
        end else begin
            wb_addr = line_addr(rd_victim_meta.tag, addr_index(rd_addr));
            wb_line = rd_data;  // Read victim is the indexed line
        end
    end

    always_comb begin
        if (serve_write) begin
            install_en         = 1'b1;
            install_index      = addr_index(wbuf_addr);
            install_meta.valid = 1'b1;
            install_meta.dirty = 1'b1;
            install_meta.tag   = addr_tag(wbuf_addr);
            install_line       = wbuf_data;
        end else begin
            // Refilled line goes in clean
            install_en         = refill_done && (state == ST_REFILL_WB || state == ST_REFILL);
            install_index      = addr_index(miss_addr);
            install_meta.valid = 1'b1;
            install_meta.dirty = 1'b0;
            install_meta.tag   = addr_tag(miss_addr);
            install_line       = refill_line;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (serve_write) begin
                    state_next = wr_conflict ? ST_WR_EVICT : ST_WR_DONE;
                end else if (serve_read) begin
                    state_next = rd_victim_dirty ? ST_REFILL_WB : ST_REFILL;
                end
            end
            ST_REFILL_WB: begin
                if (wb_done) state_next = (refill_done || refill_seen) ? ST_IDLE : ST_REFILL;
            end
            ST_REFILL:   if (refill_done) state_next = ST_IDLE;
            ST_WR_EVICT: if (wb_done) state_next = ST_WR_DONE;
            ST_WR_DONE:  state_next = ST_IDLE;
            default:     state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ST_IDLE;
            wbuf_valid    <= 1'b0;
            last_was_read <= 1'b0;
            refill_seen   <= 1'b0;
        end else begin
            state       <= state_next;
            refill_seen <= (state_next == ST_REFILL_WB) && (refill_seen || refill_done);
            if (serve_read) last_was_read <= 1'b1;
            else if (serve_write) last_was_read <= 1'b0;
            if (wr_valid && wr_ready) wbuf_valid <= 1'b1;
            else if (wr_complete) wbuf_valid <= 1'b0;  // Frees the buffer
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid && wr_ready) begin
            wbuf_addr <= wr_addr;
            wbuf_data <= wr_data;
        end
        if (serve_read) miss_addr <= refill_addr;
    end

endmodule

// ==== hdl/llc_axi_refill.sv ====
`timescale 1ns/10ps
`include "llc_defs.svh"

module llc_axi_refill (
    input  logic                clk,
    input  logic                reset,
    input  logic                refill_start,
    input  llc_pkg::addr_t      refill_addr,
    output logic                refill_done,
    output llc_pkg::line_data_t refill_line,
    input  logic                arready,
    output llc_pkg::addr_t      araddr,
    output logic                arvalid,
    input  llc_pkg::beat_t      rdata,
    input  logic                rlast,
    input  logic                rvalid,
    output logic                rready
);
    import llc_pkg::*;

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_ADDR,
        RF_DATA
    } rf_state_t;

    rf_state_t   state;
    beat_count_t beat;

    assign arvalid = (state == RF_ADDR);
    assign rready  = (state == RF_DATA);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= RF_IDLE;
            beat        <= '0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= 1'b0;
            case (state)
                RF_IDLE: begin
                    if (refill_start) begin
                        state <= RF_ADDR;
                        beat  <= '0;
                    end
                end
                RF_ADDR: if (arready) state <= RF_DATA;
                RF_DATA: begin
                    if (rvalid) begin
                        beat <= beat + beat_count_t'(1);
                        if (rlast) begin  // Burst ends on rlast
                            state       <= RF_IDLE;
                            refill_done <= 1'b1;
                        end
                    end
                end
                default: state <= RF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (refill_start && state == RF_IDLE) araddr <= refill_addr;
        if (state == RF_DATA && rvalid) begin
            refill_line[beat * `LLC_BEAT_BITS +: `LLC_BEAT_BITS] <= rdata;  // Beat k fills bits 64k up
        end
    end

endmodule

// ==== hdl/llc_axi_writeback.sv ====
`timescale 1ns/10ps
`include "llc_defs.svh"

module llc_axi_writeback (
    input  logic                clk,
    input  logic                reset,
    input  logic                wb_start,
    input  llc_pkg::addr_t      wb_addr,
    input  llc_pkg::line_data_t wb_line,
    output logic                wb_done,
    input  logic                awready,
    output llc_pkg::addr_t      awaddr,
    output logic                awvalid,
    output llc_pkg::beat_t      wdata,
    output logic                wlast,
    output logic                wvalid,
    input  logic                wready,
    input  logic                bvalid,
    output logic                bready
);
    import llc_pkg::*;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_ADDR,
        WB_DATA,
        WB_RESP
    } wb_state_t;

    wb_state_t   state;
    beat_count_t beat;
    line_data_t  line_q;  // Victim copy kept while the store changes
    logic        last_beat;

    assign last_beat = (beat == beat_count_t'(`LLC_BEATS_PER_LINE - 1));

    assign awvalid = (state == WB_ADDR);
    assign wvalid  = (state == WB_DATA);
    assign wlast   = wvalid && last_beat;
    assign wdata   = line_q[beat * `LLC_BEAT_BITS +: `LLC_BEAT_BITS];
    assign bready  = (state == WB_RESP);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= WB_IDLE;
            beat    <= '0;
            wb_done <= 1'b0;
        end else begin
            wb_done <= 1'b0;
            case (state)
                WB_IDLE: begin
                    if (wb_start) begin
                        state <= WB_ADDR;
                        beat  <= '0;
                    end
                end
                WB_ADDR: if (awready) state <= WB_DATA;
                WB_DATA: begin
                    if (wready) begin  // Advance only on handshake
                        beat <= beat + beat_count_t'(1);
                        if (last_beat) state <= WB_RESP;
                    end
                end
                WB_RESP: begin
                    if (bvalid) begin
                        state   <= WB_IDLE;
                        wb_done <= 1'b1;
                    end
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wb_start && state == WB_IDLE) begin
            awaddr <= wb_addr;
            line_q <= wb_line;
        end
    end

endmodule

// ==== hdl/llc_top.sv ====
`timescale 1ns/10ps

module llc_top (
    input  logic                clk,
    input  logic                reset,
    // Client read port
    input  llc_pkg::addr_t      rd_addr,
    input  logic                rd_addr_valid,
    output llc_pkg::line_data_t rd_data,
    output logic                rd_data_valid,
    // Client write port
    input  logic                wr_valid,
    input  llc_pkg::addr_t      wr_addr,
    input  llc_pkg::line_data_t wr_data,
    output logic                wr_ready,
    output logic                wr_complete,
    // AXI read channels
    input  logic                arready,
    output llc_pkg::addr_t      araddr,
    output logic                arvalid,
    input  llc_pkg::beat_t      rdata,
    input  logic                rlast,
    input  logic                rvalid,
    output logic                rready,
    // AXI write channels
    output logic                awvalid,
    input  logic                awready,
    output llc_pkg::addr_t      awaddr,
    output llc_pkg::beat_t      wdata,
    output logic                wlast,
    output logic                wvalid,
    input  logic                wready,
    input  logic                bvalid,
    output logic                bready
);
    import llc_pkg::*;

    line_meta_t rd_victim_meta;
    addr_t      wr_lookup_addr;
    line_meta_t wr_victim_meta;
    line_data_t wr_victim_line;
    logic       install_en;
    index_t     install_index;
    line_meta_t install_meta;
    line_data_t install_line;
    logic       inv_en;
    index_t     inv_index;
    logic       refill_start;
    addr_t      refill_addr;
    logic       refill_done;
    line_data_t refill_line;
    logic       wb_start;
    addr_t      wb_addr;
    line_data_t wb_line;
    logic       wb_done;

    llc_line_store llc_line_store_inst (
        .clk, .reset, .rd_addr, .rd_data,
        .rd_hit         (rd_data_valid),
        .rd_victim_meta, .wr_lookup_addr, .wr_victim_meta, .wr_victim_line,
        .install_en, .install_index, .install_meta, .install_line,
        .inv_en, .inv_index
    );

    llc_miss_ctrl llc_miss_ctrl_inst (
        .clk, .reset, .rd_addr, .rd_addr_valid,
        .rd_hit         (rd_data_valid),
        .rd_victim_meta, .rd_data,
        .wr_valid, .wr_addr, .wr_data, .wr_ready, .wr_complete,
        .wr_lookup_addr, .wr_victim_meta, .wr_victim_line,
        .install_en, .install_index, .install_meta, .install_line,
        .inv_en, .inv_index,
        .refill_start, .refill_addr, .refill_done, .refill_line,
        .wb_start, .wb_addr, .wb_line, .wb_done
    );

    llc_axi_refill llc_axi_refill_inst (
        .clk, .reset, .refill_start, .refill_addr, .refill_done, .refill_line,
        .arready, .araddr, .arvalid, .rdata, .rlast, .rvalid, .rready
    );

    llc_axi_writeback llc_axi_writeback_inst (
        .clk, .reset, .wb_start, .wb_addr, .wb_line, .wb_done,
        .awready, .awaddr, .awvalid, .wdata, .wlast, .wvalid, .wready,
        .bvalid, .bready
    );

endmodule

// ==== dv/llc_mem_model.sv ====
`timescale 1ns/10ps
`include "llc_defs.svh"

module llc_mem_model (
    input  logic           clk,
    input  logic           reset,
    input  logic           stall_en,
    input  llc_pkg::addr_t araddr,
    input  logic           arvalid,
    output logic           arready,
    output llc_pkg::beat_t rdata,
    output logic           rlast,
    output logic           rvalid,
    input  logic           rready,
    input  llc_pkg::addr_t awaddr,
    input  logic           awvalid,
    output logic           awready,
    input  llc_pkg::beat_t wdata,
    input  logic           wvalid,
    output logic           wready,
    output logic           bvalid,
    input  logic           bready
);
    import llc_pkg::*;

    line_data_t  store [addr_t];  // Lines written back override the pattern
    logic [31:0] rnd;
    logic        rd_active;
    addr_t       rd_line_addr;
    int          rd_beat;
    int          wr_phase;        // 0 wait AW, 1 data, 2 response
    addr_t       wr_line_addr;
    int          wr_beat;
    line_data_t  wr_buf;
    logic        ar_hs, r_hs, aw_hs, w_hs, b_hs;
    logic        ar_req;
    logic        aw_req;
    addr_t       ar_a;
    addr_t       aw_a;
    beat_t       w_d;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic beat_t beat_pattern(input beat_t x);
        x ^= x << 13;
        x ^= x >> 7;
        x ^= x << 17;
        return x;
    endfunction

    function automatic beat_t read_beat(input addr_t a, input int k);
        if (store.exists(a)) return store[a][k*`LLC_BEAT_BITS +: `LLC_BEAT_BITS];
        return beat_pattern(a + addr_t'(k));
    endfunction

    initial begin
        arready   = 1'b0;
        rvalid    = 1'b0;
        rlast     = 1'b0;
        rdata     = '0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        rnd       = 32'h2bfca657;
        rd_active = 1'b0;
        rd_beat   = 0;
        wr_phase  = 0;
        wr_beat   = 0;
        forever begin
            @(negedge clk);  // Handshakes seen here complete at the next edge
            ar_hs  = arvalid && arready;
            r_hs   = rvalid && rready;
            aw_hs  = awvalid && awready;
            w_hs   = wvalid && wready;
            b_hs   = bvalid && bready;
            ar_req = arvalid;
            aw_req = awvalid;
            ar_a   = araddr;
            aw_a   = awaddr;
            w_d    = wdata;
            @(posedge clk);
            #1;
            if (reset) begin
                rd_active = 1'b0;
                wr_phase  = 0;
            end else begin
                if (ar_hs) begin
                    rd_active    = 1'b1;
                    rd_line_addr = ar_a;
                    rd_beat      = 0;
                end
                if (r_hs) begin
                    if (rd_beat == `LLC_BEATS_PER_LINE - 1) rd_active = 1'b0;
                    else rd_beat++;
                end
                if (aw_hs) begin
                    wr_phase     = 1;
                    wr_line_addr = aw_a;
                    wr_beat      = 0;
                end
                if (w_hs) begin
                    wr_buf[wr_beat*`LLC_BEAT_BITS +: `LLC_BEAT_BITS] = w_d;
                    if (wr_beat == `LLC_BEATS_PER_LINE - 1) begin
                        store[wr_line_addr] = wr_buf;
                        wr_phase = 2;
                    end else begin
                        wr_beat++;
                    end
                end
                if (b_hs) wr_phase = 0;
            end
            rnd     = xorshift32(rnd);
            // Under back-pressure a new address request always waits a cycle
            arready = !rd_active && (!stall_en || (ar_req && rnd[1:0] != 2'b00));
            rvalid  = rd_active && (!stall_en || rnd[3:2] != 2'b00);
            rdata   = rd_active ? read_beat(rd_line_addr, rd_beat) : '0;
            rlast   = rd_active && (rd_beat == `LLC_BEATS_PER_LINE - 1);
            awready = (wr_phase == 0) && (!stall_en || (aw_req && rnd[5:4] != 2'b00));
            wready  = (wr_phase == 1) && (!stall_en || rnd[7:6] != 2'b00);
            bvalid  = (wr_phase == 2) && (!stall_en || rnd[9:8] != 2'b00);
        end
    end

endmodule

// ==== dv/llc_tb.sv ====
`timescale 1ns/10ps
`include "llc_defs.svh"

module llc_tb;
    import llc_pkg::*;

    localparam int CYCLE_LIMIT = 20 * (2 * `LLC_BEATS_PER_LINE * 4 + 20);

    logic       clk;
    logic       reset;
    logic       stall_en;
    addr_t      rd_addr;
    logic       rd_addr_valid;
    line_data_t rd_data;
    logic       rd_data_valid;
    logic       wr_valid;
    addr_t      wr_addr;
    line_data_t wr_data;
    logic       wr_ready;
    logic       wr_complete;
    logic       arready, arvalid, rlast, rvalid, rready;
    addr_t      araddr;
    beat_t      rdata;
    logic       awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    addr_t      awaddr;
    beat_t      wdata;

    int          cycle_count;
    logic [31:0] rnd_state;
    line_data_t  shadow [addr_t];  // Last data written per line
    addr_t       ar_log [$];
    addr_t       aw_log [$];
    beat_t       w_log  [$];

    llc_top llc_top_inst (.*);
    llc_mem_model mem_model_inst (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $fatal(1, "Timeout");
        end
    end

    task automatic report_failure(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "Check failed");
    endtask

    // Handshakes observed at negedge complete at the next edge
    always @(negedge clk) begin
        if (arvalid && arready) ar_log.push_back(araddr);
        if (awvalid && awready) aw_log.push_back(awaddr);
        if (wvalid && wready) begin
            assert (wlast == (w_log.size() == `LLC_BEATS_PER_LINE - 1))
                else report_failure("wlast not on the eighth beat");
            w_log.push_back(wdata);
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (arvalid && !arready) |=> (arvalid && $stable(araddr)))
        else report_failure("AR request dropped or changed before arready");
    assert property (@(posedge clk) disable iff (reset)
        (awvalid && !awready) |=> (awvalid && $stable(awaddr)))
        else report_failure("AW request dropped or changed before awready");

    function automatic beat_t fill_beat(input beat_t x);
        x ^= x << 13;
        x ^= x >> 7;
        x ^= x << 17;
        return x;
    endfunction

    function automatic line_data_t expected_line(input addr_t a);
        line_data_t l;
        if (shadow.exists(a)) return shadow[a];
        for (int k = 0; k < `LLC_BEATS_PER_LINE; k++) begin
            l[k*`LLC_BEAT_BITS +: `LLC_BEAT_BITS] = fill_beat(a + addr_t'(k));
        end
        return l;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state ^= rnd_state << 13;
        rnd_state ^= rnd_state >> 17;
        rnd_state ^= rnd_state << 5;
        return rnd_state;
    endfunction

    function automatic line_data_t random_line();
        line_data_t l;
        for (int k = 0; k < `LLC_LINE_BITS / 32; k++) l[k*32 +: 32] = next_rand();
        return l;
    endfunction

    function automatic addr_t make_addr(input int tag, input int index);
        return {tag_t'(tag), index_t'(index), {`LLC_OFFSET_BITS{1'b0}}};
    endfunction

    task automatic next_drive_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic check_victim_beats(input addr_t victim, input line_data_t old);
        assert (aw_log.size() == 1 && aw_log[0] == victim)
            else report_failure("Writeback address is not the victim line");
        assert (w_log.size() == `LLC_BEATS_PER_LINE)
            else report_failure("Writeback did not send eight beats");
        for (int k = 0; k < `LLC_BEATS_PER_LINE; k++) begin
            assert (w_log[k] == old[k*`LLC_BEAT_BITS +: `LLC_BEAT_BITS])
                else report_failure("Writeback beat differs from victim data");
        end
    endtask

    task automatic read_miss(input addr_t a, input logic expect_wb, input addr_t victim);
        line_data_t exp;
        line_data_t old;
        exp = expected_line(a);
        old = expected_line(victim);
        ar_log.delete();
        aw_log.delete();
        w_log.delete();
        rd_addr       = a + addr_t'(24);  // Unaligned byte address within the line
        rd_addr_valid = 1'b1;
        @(negedge clk);
        while (!rd_data_valid) @(negedge clk);
        assert (rd_data == exp) else report_failure("Refilled line has wrong data");
        assert (ar_log.size() == 1 && ar_log[0] == a)
            else report_failure("araddr is not the line-aligned address");
        if (expect_wb) begin
            while (w_log.size() < `LLC_BEATS_PER_LINE) @(negedge clk);
            check_victim_beats(victim, old);
        end else begin
            assert (aw_log.size() == 0) else report_failure("Unexpected writeback");
        end
        next_drive_slot();
        rd_addr_valid = 1'b0;
    endtask

    task automatic read_hit(input addr_t a);
        ar_log.delete();
        rd_addr       = a + addr_t'(8);
        rd_addr_valid = 1'b1;
        @(negedge clk);
        assert (rd_data_valid && rd_data == shadow[a])
            else report_failure("Read after write did not hit with written data");
        repeat (3) @(negedge clk);
        assert (ar_log.size() == 0 && !arvalid) else report_failure("Read hit issued AR");
        next_drive_slot();
        rd_addr_valid = 1'b0;
    endtask

    task automatic write_line(input addr_t a, input logic expect_wb, input addr_t victim);
        line_data_t d;
        line_data_t old;
        d   = random_line();
        old = expected_line(victim);
        aw_log.delete();
        w_log.delete();
        wr_addr  = a;
        wr_data  = d;
        wr_valid = 1'b1;
        @(negedge clk);
        while (!wr_ready) @(negedge clk);
        next_drive_slot();
        wr_valid = 1'b0;
        @(negedge clk);
        while (!wr_complete) @(negedge clk);
        if (expect_wb) check_victim_beats(victim, old);
        else assert (aw_log.size() == 0) else report_failure("Unexpected writeback");
        shadow[a] = d;
        next_drive_slot();
    endtask

    task automatic run_phase(input int p);
        addr_t a0;
        addr_t x;
        addr_t y;
        a0 = make_addr(32'h123 + p, 1 + 4 * p);
        x  = make_addr(32'h40 + p, 2 + 4 * p);
        y  = make_addr(32'h77 + p, 2 + 4 * p);  // Same index as x
        stall_en = p[0];
        read_miss(a0, 1'b0, '0);
        write_line(x, 1'b0, '0);
        read_hit(x);
        write_line(y, 1'b1, x);                 // Evicts dirty x
        read_miss(x, 1'b1, y);                  // Dirty y goes out while x comes back
        read_miss(y, 1'b0, '0);
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        stall_en      = 1'b0;
        rd_addr       = '0;
        rd_addr_valid = 1'b0;
        wr_valid      = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        cycle_count   = 0;
        rnd_state     = 32'h2bfca657;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < `LLC_LINE_COUNT; i++) begin
            rd_addr = make_addr(3 * i, i);
            @(negedge clk);
            assert (!rd_data_valid) else report_failure("Line valid after reset");
            assert (wr_ready && !arvalid && !awvalid && !wvalid && !wr_complete &&
                    !rready && !wlast && !bready)
                else report_failure("Control outputs wrong after reset");
            next_drive_slot();
        end
        run_phase(0);
        run_phase(1);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== llc_cache.f ====
+incdir+hdl
hdl/llc_pkg.sv
hdl/llc_line_store.sv
hdl/llc_miss_ctrl.sv
hdl/llc_axi_refill.sv
hdl/llc_axi_writeback.sv
hdl/llc_top.sv
dv/llc_mem_model.sv
dv/llc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the llc_cache simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f llc_cache.f --top-module llc_tb -o llc_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/llc_sim > "$LOG" 2>&1
SIM_STATUS=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $SIM_STATUS -ne 0 ]; then
    echo "Simulation exited with status $SIM_STATUS"
    exit 1
fi

echo "Simulation passed"
exit 0
